// ==== flist.f ====
+incdir+hw
hw/trap_pkg.sv
hw/trap_arbiter.sv
hw/csr_file.sv
hw/mtime_timer.sv
hw/trap_unit.sv
tests/trap_properties.sv
tests/tb_trap_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the trap unit testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_trap_unit \
    -f flist.f \
    -o sim_trap_unit

./obj_dir/sim_trap_unit +verilator+error+limit+100 | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/tb_trap_unit.sv ====
// Directed testbench for the trap unit; simulation top, runs all tests and prints the verdict.
`timescale 1ns/1ps
`include "trap_defs.svh"

module tb_trap_unit import trap_pkg::*; ();

    localparam int          clk_period        = 4;
    localparam int          watchdog_cycles   = 2000;
    localparam int          timer_wait_limit  = 100;
    localparam int unsigned rand_seed         = 32'h3ccedfac;
    localparam xlen_t       hart_id           = 32'h0000_0005;

    logic         clk;
    logic         rst;
    csr_addr_t    csr_addr;
    logic         csr_we;
    xlen_t        csr_wdata;
    xlen_t        csr_rdata;
    logic         csr_exists;
    logic         csr_rdonly;
    logic         retire_valid;
    logic         retire_trap;
    cause_t       retire_cause;
    pc_t          retire_pc;
    logic         mret;
    logic [31:16] irq;
    logic         timer_sel;
    logic         timer_we;
    logic [1:0]   timer_offset;
    xlen_t        timer_wdata;
    xlen_t        timer_rdata;
    logic         exception;
    tvec_t        trap_vector;
    pc_t          ret_epc;
    logic         mstatus_mie;

    // Bookkeeping for the per-test and closing reports.
    int           error_count = 0;
    int           test_errors_at_start = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    // Flags of the most recent CSR read.
    logic         read_exists;
    logic         read_rdonly;

    trap_unit #(
        .hartid (hart_id)
    ) u_trap_unit (
        .clk          (clk),
        .rst          (rst),
        .csr_addr     (csr_addr),
        .csr_we       (csr_we),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .csr_exists   (csr_exists),
        .csr_rdonly   (csr_rdonly),
        .retire_valid (retire_valid),
        .retire_trap  (retire_trap),
        .retire_cause (retire_cause),
        .retire_pc    (retire_pc),
        .mret         (mret),
        .irq          (irq),
        .timer_sel    (timer_sel),
        .timer_we     (timer_we),
        .timer_offset (timer_offset),
        .timer_wdata  (timer_wdata),
        .timer_rdata  (timer_rdata),
        .exception    (exception),
        .trap_vector  (trap_vector),
        .ret_epc      (ret_epc),
        .mstatus_mie  (mstatus_mie)
    );

    bind trap_unit trap_properties u_props (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .exception    (exception),
        .mstatus_mie  (mstatus_mie),
        .trap_vector  (trap_vector)
    );

    always #(clk_period / 2) clk = ~clk;

    // Next edge, then the drive point 1 ns later.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s = %b, expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic begin_test();
        test_errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        int new_errors;
        new_errors = error_count - test_errors_at_start;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, new_errors);
        end
    endtask

    // Reads settle by 3 ns after the edge, well before the next one.
    task automatic csr_read(input csr_addr_t addr, output xlen_t data);
        csr_addr = addr;
        csr_we   = 1'b0;
        #2;
        data        = csr_rdata;
        read_exists = csr_exists;
        read_rdonly = csr_rdonly;
        step();
    endtask

    task automatic check_csr(input string name, input csr_addr_t addr, input xlen_t exp);
        xlen_t data;
        csr_read(addr, data);
        check_word(name, data, exp);
    endtask

    task automatic csr_write(input csr_addr_t addr, input xlen_t data);
        csr_addr  = addr;
        csr_we    = 1'b1;
        csr_wdata = data;
        step();
        csr_we    = 1'b0;
    endtask

    task automatic timer_write(input logic [1:0] offset, input xlen_t data);
        timer_sel    = 1'b1;
        timer_we     = 1'b1;
        timer_offset = offset;
        timer_wdata  = data;
        step();
        timer_sel    = 1'b0;
        timer_we     = 1'b0;
    endtask

    task automatic timer_read(input logic [1:0] offset, output xlen_t data);
        timer_sel    = 1'b1;
        timer_we     = 1'b0;
        timer_offset = offset;
        #2;
        data      = timer_rdata;
        timer_sel = 1'b0;
        step();
    endtask

    // One committing instruction; exception and vector are sampled in its cycle.
    task automatic retire_one(input logic trap, input cause_t cause, input pc_t pc,
                              output logic exc_seen, output tvec_t vec_seen);
        retire_valid = 1'b1;
        retire_trap  = trap;
        retire_cause = cause;
        retire_pc    = pc;
        #2;
        exc_seen = exception;
        vec_seen = trap_vector;
        step();
        retire_valid = 1'b0;
        retire_trap  = 1'b0;
    endtask

    task automatic pulse_mret();
        mret = 1'b1;
        step();
        mret = 1'b0;
    endtask

    task automatic test_reset_state();
        xlen_t data;
        logic  exc_seen;
        tvec_t vec_seen;
        begin_test();
        check_csr("mvendorid", `CSR_MVENDORID, 32'h0);
        check_bit("mvendorid csr_rdonly", read_rdonly, 1'b1);
        check_csr("marchid", `CSR_MARCHID, `MARCHID_VALUE);
        check_bit("marchid csr_rdonly", read_rdonly, 1'b1);
        check_csr("mimpid", `CSR_MIMPID, `MIMPID_VALUE);
        check_bit("mimpid csr_rdonly", read_rdonly, 1'b1);
        check_csr("mhartid", `CSR_MHARTID, 32'h0000_0005);
        check_bit("mhartid csr_rdonly", read_rdonly, 1'b1);
        check_csr("misa", `CSR_MISA, `MISA_VALUE);
        check_csr("mscratch", `CSR_MSCRATCH, 32'h0);
        check_bit("mscratch csr_rdonly", read_rdonly, 1'b0);
        check_csr("mie", `CSR_MIE, 32'h0);
        check_csr("mepc", `CSR_MEPC, 32'h0);
        // Custom machine range, nothing lives there.
        csr_read(12'h7C0, data);
        check_bit("csr_exists", read_exists, 1'b0);
        // A plain retire with nothing enabled must not trap.
        retire_one(1'b0, 5'd0, 31'h0, exc_seen, vec_seen);
        check_bit("exception", exc_seen, 1'b0);
        end_test("reset state and constants");
    endtask

    task automatic test_csr_writes();
        xlen_t w;
        begin_test();
        for (int i = 0; i < 4; i++) begin
            w = $urandom;
            csr_write(`CSR_MSCRATCH, w);
            check_csr("mscratch", `CSR_MSCRATCH, w);
        end
        w = $urandom;
        csr_write(`CSR_MTVEC, w);
        check_csr("mtvec", `CSR_MTVEC, {w[31:2], 2'b00});
        w = $urandom;
        csr_write(`CSR_MEPC, w);
        check_csr("mepc", `CSR_MEPC, {w[31:1], 1'b0});
        // Read-only ID register must ignore the write.
        csr_write(`CSR_MVENDORID, $urandom);
        check_csr("mvendorid", `CSR_MVENDORID, 32'h0);
        end_test("csr writes");
    endtask

    task automatic test_trap_mret();
        xlen_t tvec_w;
        xlen_t pc_w;
        logic  exc_seen;
        tvec_t vec_seen;
        begin_test();
        tvec_w = $urandom;
        pc_w   = $urandom;
        csr_write(`CSR_MTVEC, tvec_w);
        // MIE is bit 3, MPIE bit 7.
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        retire_one(1'b1, 5'd2, pc_w[31:1], exc_seen, vec_seen);
        check_bit("exception", exc_seen, 1'b1);
        check_word("trap_vector", {vec_seen, 2'b00}, {tvec_w[31:2], 2'b00});
        check_csr("mcause", `CSR_MCAUSE, 32'h0000_0002);
        check_csr("mepc", `CSR_MEPC, {pc_w[31:1], 1'b0});
        check_word("ret_epc", {ret_epc, 1'b0}, {pc_w[31:1], 1'b0});
        check_csr("mstatus", `CSR_MSTATUS, 32'h0000_0080);
        pulse_mret();
        check_bit("mstatus_mie", mstatus_mie, 1'b1);
        check_csr("mstatus", `CSR_MSTATUS, 32'h0000_0088);
        end_test("synchronous trap and mret");
    endtask

    task automatic test_external_irq();
        xlen_t pc_w;
        logic  exc_seen;
        tvec_t vec_seen;
        begin_test();
        pc_w = $urandom;
        csr_write(`CSR_MIE, (32'h1 << 20) | (32'h1 << 25));
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        irq[20] = 1'b1;
        irq[25] = 1'b1;
        repeat (4) step();
        // The trap is overridden by the lowest pending line.
        retire_one(1'b1, 5'd3, pc_w[31:1], exc_seen, vec_seen);
        check_bit("exception", exc_seen, 1'b1);
        check_bit("mstatus_mie", mstatus_mie, 1'b0);
        check_csr("mcause", `CSR_MCAUSE, 32'h8000_0014);
        check_csr("mip", `CSR_MIP, (32'h1 << 20) | (32'h1 << 25));
        irq = '0;
        csr_write(`CSR_MIE, 32'h0);
        end_test("external interrupts");
    endtask

    task automatic test_timer_irq();
        xlen_t first;
        xlen_t second;
        xlen_t data;
        xlen_t pc_w;
        logic  seen;
        int    waited;
        logic  exc_seen;
        tvec_t vec_seen;
        begin_test();
        pc_w = $urandom;
        timer_write(`MTIMECMP_HI, 32'h0);
        timer_write(`MTIMECMP_LO, 32'd40);
        timer_write(`MTIME_HI, 32'h0);
        timer_write(`MTIME_LO, 32'h0);
        timer_read(`MTIME_LO, first);
        timer_read(`MTIME_LO, second);
        if (first >= 32'd40 || second <= first) begin
            $display("[ERROR] %0t ns: mtime = %0d then %0d, expected a small rising count",
                     $time, first, second);
            error_count++;
        end
        csr_write(`CSR_MIE, 32'h1 << `TIMER_IRQ);
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        // Poll until the compare has been reached.
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < timer_wait_limit) begin
            csr_read(`CSR_MIP, data);
            seen = data[`TIMER_IRQ];
            waited++;
        end
        if (!seen) begin
            $display("timer interrupt did not become pending within %0d cycles",
                     timer_wait_limit);
            error_count++;
        end
        retire_one(1'b0, 5'd0, pc_w[31:1], exc_seen, vec_seen);
        check_bit("exception", exc_seen, 1'b1);
        check_csr("mcause", `CSR_MCAUSE, 32'h8000_0007);
        timer_write(`MTIMECMP_HI, 32'hFFFF_FFFF);
        // Pending follows the level one cycle late.
        step();
        check_csr("mip", `CSR_MIP, 32'h0);
        csr_write(`CSR_MIE, 32'h0);
        end_test("timer interrupt");
    endtask

    // Watchdog.
    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        csr_addr     = '0;
        csr_we       = 1'b0;
        csr_wdata    = '0;
        retire_valid = 1'b0;
        retire_trap  = 1'b0;
        retire_cause = '0;
        retire_pc    = '0;
        mret         = 1'b0;
        irq          = '0;
        timer_sel    = 1'b0;
        timer_we     = 1'b0;
        timer_offset = '0;
        timer_wdata  = '0;
        void'($urandom(rand_seed));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_csr_writes();
        test_trap_mret();
        test_external_irq();
        test_timer_irq();
        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, u_trap_unit.u_props.fail_count);
        if (error_count == 0 && tests_failed == 0 && u_trap_unit.u_props.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tests/trap_properties.sv ====
// Assertion checks on the trap unit top level; bound into trap_unit by the testbench.
`timescale 1ns/1ps

module trap_properties import trap_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  retire_valid,
    input logic  exception,
    input logic  mstatus_mie,
    input tvec_t trap_vector
);

    // Failed assertions so far, read by the testbench at the end.
    int unsigned fail_count = 0;

    // Only a retiring instruction can trap or take an interrupt.
    exception_needs_retire: assert property (
        @(posedge clk) disable iff (rst) exception |-> retire_valid
    ) else begin
        fail_count = fail_count + 1;
        $error("exception raised without retire_valid");
    end

    // Trap entry always clears the global enable.
    mie_clear_after_trap: assert property (
        @(posedge clk) disable iff (rst) exception |=> !mstatus_mie
    ) else begin
        fail_count = fail_count + 1;
        $error("mstatus_mie still set in the cycle after a trap");
    end

    // The redirect target is always defined once out of reset.
    trap_vector_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(trap_vector)
    ) else begin
        fail_count = fail_count + 1;
        $error("trap_vector has unknown bits");
    end

endmodule

// ==== hw/trap_unit.sv ====
// Top of the machine-mode trap unit; connects arbiter, CSR file and timer at the commit point.
`timescale 1ns/1ps

module trap_unit import trap_pkg::*; #(
    // Value read from mhartid.
    parameter xlen_t hartid = 32'h0000_0000
) (
    input  logic         clk,
    input  logic         rst,

    // CSR access.
    input  csr_addr_t    csr_addr,
    input  logic         csr_we,
    input  xlen_t        csr_wdata,
    output xlen_t        csr_rdata,
    output logic         csr_exists,
    output logic         csr_rdonly,

    // Commit port.
    input  logic         retire_valid,
    input  logic         retire_trap,
    input  cause_t       retire_cause,
    input  pc_t          retire_pc,
    input  logic         mret,

    // External interrupt lines 16 to 31.
    input  logic [31:16] irq,

    // Timer word access.
    input  logic         timer_sel,
    input  logic         timer_we,
    input  logic [1:0]   timer_offset,
    input  xlen_t        timer_wdata,
    output xlen_t        timer_rdata,

    // Redirect info to the pipeline.
    output logic         exception,
    output tvec_t        trap_vector,
    output pc_t          ret_epc,
    output logic         mstatus_mie
);

    irq_vec_t irq_pending;
    irq_vec_t irq_enable_mask;
    logic     exception_is_irq;
    cause_t   exception_cause;
    logic     timer_irq;

    trap_arbiter u_arbiter (
        .clk              (clk),
        .rst              (rst),
        .irq              (irq),
        .timer_irq        (timer_irq),
        .irq_enable_mask  (irq_enable_mask),
        .mstatus_mie      (mstatus_mie),
        .retire_valid     (retire_valid),
        .retire_trap      (retire_trap),
        .retire_cause     (retire_cause),
        .irq_pending      (irq_pending),
        .exception        (exception),
        .exception_is_irq (exception_is_irq),
        .exception_cause  (exception_cause)
    );

    csr_file #(
        .hartid (hartid)
    ) u_csrs (
        .clk              (clk),
        .rst              (rst),
        .csr_addr         (csr_addr),
        .csr_we           (csr_we),
        .csr_wdata        (csr_wdata),
        .csr_rdata        (csr_rdata),
        .csr_exists       (csr_exists),
        .csr_rdonly       (csr_rdonly),
        .irq_pending      (irq_pending),
        .exception        (exception),
        .exception_is_irq (exception_is_irq),
        .exception_cause  (exception_cause),
        .exception_pc     (retire_pc),
        .mret             (mret),
        .irq_enable_mask  (irq_enable_mask),
        .trap_vector      (trap_vector),
        .ret_epc          (ret_epc),
        .mstatus_mie      (mstatus_mie)
    );

    mtime_timer u_timer (
        .clk          (clk),
        .rst          (rst),
        .timer_sel    (timer_sel),
        .timer_we     (timer_we),
        .timer_offset (timer_offset),
        .timer_wdata  (timer_wdata),
        .timer_rdata  (timer_rdata),
        .timer_irq    (timer_irq)
    );

endmodule

// ==== hw/mtime_timer.sv ====
// Machine timer; free-running 64-bit cycle counter with compare, accessed as 32-bit words.
`timescale 1ns/1ps
`include "trap_defs.svh"

module mtime_timer import trap_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // Word access port.
    input  logic       timer_sel,
    input  logic       timer_we,
    input  logic [1:0] timer_offset,
    input  xlen_t      timer_wdata,
    output xlen_t      timer_rdata,

    // Level interrupt, high while mtime >= mtimecmp.
    output logic       timer_irq
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    // Counter value for the next edge.
    logic [63:0] mtime_next;
    logic        wr_en;

    assign wr_en = timer_sel && timer_we;

    // Increment, then let a written half replace its part.
    always_comb begin
        mtime_next = mtime + 64'd1;
        if (wr_en && timer_offset == `MTIME_LO) begin
            mtime_next[31:0] = timer_wdata;
        end
        if (wr_en && timer_offset == `MTIME_HI) begin
            mtime_next[63:32] = timer_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            // Compare starts at the top so nothing fires.
            mtimecmp <= '1;
        end else begin
            mtime <= mtime_next;
            if (wr_en && timer_offset == `MTIMECMP_LO) begin
                mtimecmp[31:0] <= timer_wdata;
            end
            if (wr_en && timer_offset == `MTIMECMP_HI) begin
                mtimecmp[63:32] <= timer_wdata;
            end
        end
    end

    // Read mux.
    always_comb begin
        case (timer_offset)
            `MTIME_LO:    timer_rdata = mtime[31:0];
            `MTIME_HI:    timer_rdata = mtime[63:32];
            `MTIMECMP_LO: timer_rdata = mtimecmp[31:0];
            default:      timer_rdata = mtimecmp[63:32];
        endcase
    end

    assign timer_irq = (mtime >= mtimecmp);

endmodule

// ==== hw/csr_file.sv ====
// Machine-mode CSR file; holds trap state, decodes reads and applies trap entry and MRET.
`timescale 1ns/1ps
`include "trap_defs.svh"

module csr_file import trap_pkg::*; #(
    // Value read from mhartid.
    parameter xlen_t hartid = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst,

    // CSR access from the pipeline.
    input  csr_addr_t csr_addr,
    input  logic      csr_we,
    input  xlen_t     csr_wdata,
    output xlen_t     csr_rdata,
    output logic      csr_exists,
    output logic      csr_rdonly,

    // Latched interrupt lines.
    input  irq_vec_t  irq_pending,

    // Trap entry from the arbiter.
    input  logic      exception,
    input  logic      exception_is_irq,
    input  cause_t    exception_cause,
    input  pc_t       exception_pc,

    // Return from trap.
    input  logic      mret,

    output irq_vec_t  irq_enable_mask,
    output tvec_t     trap_vector,
    output pc_t       ret_epc,
    output logic      mstatus_mie
);

    // Previous interrupt enable, restored by MRET.
    logic     mstatus_mpie;
    // Per-interrupt enables.
    irq_vec_t mie;
    // Trap vector base, direct mode only.
    tvec_t    mtvec;
    xlen_t    mscratch;
    pc_t      mepc;
    // Interrupt flag of mcause.
    logic     mcause_int;
    // Cause number of mcause.
    cause_t   mcause_num;

    // Pending lines are only visible where enabled.
    irq_vec_t mip;

    assign mip             = irq_pending & mie;
    assign irq_enable_mask = mie;
    assign trap_vector     = mtvec;
    assign ret_epc         = mepc;

    // Read decode.
    // Zero CSRs keep the default value.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            `CSR_MSTATUS: begin
                // MPIE at bit 7, MIE at bit 3.
                csr_rdata = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
            end
            `CSR_MISA: begin
                csr_rdata = `MISA_VALUE;
            end
            `CSR_MEDELEG, `CSR_MIDELEG, `CSR_MSTATUSH, `CSR_MTVAL: begin
                // Hardwired zero, writes are dropped.
                csr_rdata = '0;
            end
            `CSR_MIE:      csr_rdata = mie;
            `CSR_MTVEC:    csr_rdata = {mtvec, 2'b00};
            `CSR_MIP:      csr_rdata = mip;
            `CSR_MSCRATCH: csr_rdata = mscratch;
            `CSR_MEPC:     csr_rdata = {mepc, 1'b0};
            `CSR_MCAUSE: begin
                csr_rdata = {mcause_int, 26'b0, mcause_num};
            end
            `CSR_MVENDORID, `CSR_MCONFIGPTR: begin
                csr_rdonly = 1'b1;
            end
            `CSR_MARCHID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = `MARCHID_VALUE;
            end
            `CSR_MIMPID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = `MIMPID_VALUE;
            end
            `CSR_MHARTID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = hartid;
            end
            default: begin
                // Unimplemented address.
                csr_exists = 1'b0;
            end
        endcase
    end

    // Updates in priority order: reset, trap entry, CSR write, MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_num   <= '0;
        end else if (exception) begin
            // Trap entry, stack the enable and record the cause.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= exception_pc;
            mcause_int   <= exception_is_irq;
            mcause_num   <= exception_cause;
        end else if (csr_we) begin
            // Read-only and unknown addresses fall through.
            case (csr_addr)
                `CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                `CSR_MIE:      mie      <= csr_wdata;
                `CSR_MTVEC:    mtvec    <= csr_wdata[31:2];
                `CSR_MSCRATCH: mscratch <= csr_wdata;
                `CSR_MEPC:     mepc     <= csr_wdata[31:1];
                `CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[31];
                    mcause_num <= csr_wdata[4:0];
                end
                default: ;
            endcase
        end else if (mret) begin
            // Restore the enable saved at trap entry.
            mstatus_mie <= mstatus_mpie;
        end
    end

endmodule

// ==== hw/trap_arbiter.sv ====
// Latches interrupt lines, applies the delayed enable and picks interrupt or trap per retire.
`timescale 1ns/1ps
`include "trap_defs.svh"

module trap_arbiter import trap_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // External lines 16 to 31 and the timer level.
    input  logic [31:16] irq,
    input  logic        timer_irq,

    // Enables from the CSR file.
    input  irq_vec_t    irq_enable_mask,
    input  logic        mstatus_mie,

    // Retiring instruction.
    input  logic        retire_valid,
    input  logic        retire_trap,
    input  cause_t      retire_cause,

    output irq_vec_t    irq_pending,
    output logic        exception,
    output logic        exception_is_irq,
    output cause_t      exception_cause
);

    // Next pending vector, lines placed at their mip bits.
    irq_vec_t pending_next;
    // History of mstatus.MIE, bit 0 is the newest.
    logic [`MIE_DELAY-1:0] mie_hist;
    // Pending and enabled.
    irq_vec_t irq_masked;
    logic     irq_hit;
    cause_t   irq_num;
    // Interrupts allowed this cycle.
    logic     irq_en;
    logic     take_irq;

    always_comb begin
        pending_next             = '0;
        pending_next[31:16]      = irq;
        pending_next[`TIMER_IRQ] = timer_irq;
    end

    // One cycle of latency from pin to pending.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
            mie_hist    <= '0;
        end else begin
            irq_pending <= pending_next;
            mie_hist[0] <= mstatus_mie;
            for (int i = 1; i < `MIE_DELAY; i++) begin
                mie_hist[i] <= mie_hist[i-1];
            end
        end
    end

    assign irq_masked = irq_pending & irq_enable_mask;
    assign irq_hit    = |irq_masked;

    // Scan downwards so the lowest set bit wins.
    always_comb begin
        irq_num = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_masked[i]) begin
                irq_num = cause_t'(i);
            end
        end
    end

    // MIE must have held through the whole history.
    assign irq_en   = (&mie_hist) && mstatus_mie;
    assign take_irq = irq_hit && irq_en && retire_valid;

    // Interrupts override a synchronous trap.
    assign exception        = take_irq || (retire_valid && retire_trap);
    assign exception_is_irq = take_irq;
    assign exception_cause  = take_irq ? irq_num : retire_cause;

endmodule

// ==== hw/trap_pkg.sv ====
// Vector types shared by the trap unit RTL and its testbench; import where needed.
package trap_pkg;

    // Plain data word.
    typedef logic [31:0] xlen_t;

    // CSR address.
    typedef logic [11:0] csr_addr_t;

    // Halfword-aligned PC, bit 0 is implied zero.
    typedef logic [31:1] pc_t;

    // Trap vector base, bits 1 to 0 are implied zero.
    typedef logic [31:2] tvec_t;

    // Trap or interrupt number as stored in mcause.
    typedef logic [4:0] cause_t;

    // Interrupt bit vector, same layout as mip and mie.
    typedef logic [31:0] irq_vec_t;

endpackage

// ==== hw/trap_defs.svh ====
// Shared constants for the trap unit: CSR addresses, ID values, timer offsets and delays.
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

// Machine trap setup CSRs.
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSTATUSH    12'h310

// Machine trap handling CSRs.
`define CSR_MIP         12'h344
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343

// Machine information CSRs, all read-only.
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13
`define CSR_MHARTID     12'hF14
`define CSR_MCONFIGPTR  12'hF15

// Fixed ID values.
`define MARCHID_VALUE   32'd37
// Version 1.4.0, divider latency field 2.
`define MIMPID_VALUE    32'h0002_0140
// MXL 1 with I, M, A and C.
`define MISA_VALUE      32'h4000_1105

// Cycles of MIE high before interrupts are taken.
`define MIE_DELAY       2
// Timer interrupt bit and cause number.
`define TIMER_IRQ       7

// Timer word offsets.
`define MTIME_LO        2'd0
`define MTIME_HI        2'd1
`define MTIMECMP_LO     2'd2
`define MTIMECMP_HI     2'd3

`endif
